// File: verilog.f
+incdir+common
common/attn_pkg.sv
logic/attn_sequencer.sv
logic/input_buffer.sv
projection/projection_unit.sv
attention/score_unit.sv
attention/context_unit.sv
logic/attn_top.sv
testbench/tb_attn.sv

// File: Makefile
# Verilator simulation of the attention engine
VERILATOR ?= verilator
FILELIST  ?= verilog.f
SIM_TOP   ?= tb_attn
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR FILELIST SIM_TOP BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(SIM_TOP) \
		--Mdir $(BUILD_DIR) -o V$(SIM_TOP)
	./$(BUILD_DIR)/V$(SIM_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || \
		(echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_attn.sv
module tb_attn;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int load_cycles = 192;
    localparam int num_tests   = 5;
    localparam int wait_limit  = 1000;

    // columns: driven T, effective T, negated keys, weight range, data range
    typedef struct packed {
        logic [3:0] t_drv;
        logic [3:0] t_eff;
        logic       neg_keys;
        int         w_lo;
        int         w_hi;
        int         d_lo;
        int         d_hi;
    } test_row_t;

    localparam test_row_t tests [num_tests] = '{
        '{t_drv: 4'd8, t_eff: 4'd8, neg_keys: 1'b0, w_lo: -128, w_hi: 127, d_lo: -128, d_hi: 127},
        '{t_drv: 4'd4, t_eff: 4'd4, neg_keys: 1'b0, w_lo: -128, w_hi: 127, d_lo: -128, d_hi: 127},
        '{t_drv: 4'd1, t_eff: 4'd1, neg_keys: 1'b0, w_lo: -100, w_hi: 100, d_lo: -128, d_hi: 127},
        '{t_drv: 4'd8, t_eff: 4'd8, neg_keys: 1'b1, w_lo: 0, w_hi: 127, d_lo: 0, d_hi: 127},
        '{t_drv: 4'd3, t_eff: 4'd8, neg_keys: 1'b0, w_lo: -16, w_hi: 15, d_lo: -16, d_hi: 15}
    };

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic [3:0]          T;
    logic signed [7:0]   in_data2;
    logic signed [7:0]   w_Q;
    logic signed [7:0]   w_K;
    logic signed [7:0]   w_V;
    logic                out_valid;
    logic signed [55:0]  out_data;

    logic [31:0]         lcg_state;
    int                  x_m [64];
    int                  wq_m [64];
    int                  wk_m [64];
    int                  wv_m [64];
    longint              q_m [64];
    longint              k_m [64];
    longint              v_m [64];
    longint              s_m [64];
    logic signed [55:0]  exp_out [64];
    int                  test_errs;
    int                  total_errs;
    int                  failed_tests;
    logic                timed_out;

    attn_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .T         (T),
        .in_data2  (in_data2),
        .w_Q       (w_Q),
        .w_K       (w_K),
        .w_V       (w_V),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) & 32'h7fff);
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + (next_rand() % (hi - lo + 1));
    endfunction

    // ##################################################################
    // reference model
    // ##################################################################
    task automatic make_data(input test_row_t row);
        for (int i = 0; i < 64; i++) begin
            x_m[i]  = (i < 8 * int'(row.t_eff)) ? rand_range(row.d_lo, row.d_hi) : 0;
            wq_m[i] = rand_range(row.w_lo, row.w_hi);
            wv_m[i] = rand_range(row.w_lo, row.w_hi);
            wk_m[i] = row.neg_keys ? -wq_m[i] : rand_range(row.w_lo, row.w_hi);
        end
    endtask

    task automatic compute_expected(input int teff);
        longint             acc;
        logic signed [36:0] s37;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                q_m[i*8+j] = 0;
                k_m[i*8+j] = 0;
                v_m[i*8+j] = 0;
                for (int k = 0; k < 8; k++) begin
                    q_m[i*8+j] += longint'(x_m[i*8+k] * wq_m[k*8+j]);
                    k_m[i*8+j] += longint'(x_m[i*8+k] * wk_m[k*8+j]);
                    v_m[i*8+j] += longint'(x_m[i*8+k] * wv_m[k*8+j]);
                end
            end
        end
        // clipped q.k divided by three, kept to 37 bits
        for (int i = 0; i < 64; i++) begin
            s_m[i] = 0;
            if ((i / 8) < teff && (i % 8) < teff) begin
                acc = 0;
                for (int k = 0; k < 8; k++) begin
                    acc += q_m[(i/8)*8+k] * k_m[(i%8)*8+k];
                end
                acc    = (acc < 0) ? 0 : acc / 3;
                s37    = acc[36:0];
                s_m[i] = s37;
            end
        end
        for (int i = 0; i < 8 * teff; i++) begin
            acc = 0;
            for (int k = 0; k < teff; k++) begin
                acc += s_m[(i/8)*8+k] * v_m[k*8+(i%8)];
            end
            exp_out[i] = acc[55:0];
        end
    endtask

    // ##################################################################
    // stimulus and checks
    // ##################################################################
    task automatic check_quiet();
        if (out_valid !== 1'b0) begin
            $display("Error out_valid: expected 0, got %h", out_valid);
            test_errs++;
        end
        if (out_data !== 56'h0) begin
            $display("Error out_data: expected 00000000000000, got %h", out_data);
            test_errs++;
        end
    endtask

    task automatic drive_job(input test_row_t row);
        for (int c = 0; c < load_cycles; c++) begin
            in_valid = 1'b1;
            T        = (c == 0) ? row.t_drv : 4'd0;
            in_data2 = (c < 8 * int'(row.t_eff)) ? 8'(x_m[c]) : 8'(next_rand());
            w_Q      = (c < 64) ? 8'(wq_m[c]) : 8'd0;
            w_K      = (c >= 64 && c < 128) ? 8'(wk_m[c-64]) : 8'd0;
            w_V      = (c >= 128) ? 8'(wv_m[c-128]) : 8'd0;
            @(posedge clk);
            #2;
            check_quiet();
        end
        in_valid = 1'b0;
        T        = 4'd0;
        in_data2 = 8'd0;
        w_Q      = 8'd0;
        w_K      = 8'd0;
        w_V      = 8'd0;
    endtask

    task automatic collect_beats(input int teff, output int beats);
        int waited;
        waited = 0;
        beats  = 0;
        while (!out_valid && waited < wait_limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!out_valid) begin
            $display("timeout: out_valid did not rise within %0d cycles", wait_limit);
            timed_out = 1'b1;
            test_errs++;
        end else begin
            // a gap in the burst shows up as a short count
            while (out_valid && beats < 72) begin
                if (beats < 8 * teff && out_data !== exp_out[beats]) begin
                    $display("Error out_data[%0d]: expected %h, got %h",
                             beats, exp_out[beats], out_data);
                    test_errs++;
                end
                beats++;
                @(posedge clk);
                #2;
            end
            if (beats != 8 * teff) begin
                $display("wrong number of beats: expected %0d, got %0d", 8 * teff, beats);
                test_errs++;
            end
        end
    endtask

    task automatic run_test(input int n);
        test_row_t row;
        int        beats;
        row       = tests[n];
        test_errs = 0;
        make_data(row);
        compute_expected(int'(row.t_eff));
        drive_job(row);
        collect_beats(int'(row.t_eff), beats);
        for (int c = 0; c < 4 && !timed_out; c++) begin
            check_quiet();
            @(posedge clk);
            #2;
        end
        $display("test %0d: T=%0d, %0d beats, %0d errors", n, row.t_drv, beats, test_errs);
        total_errs += test_errs;
        if (test_errs != 0) begin
            failed_tests++;
        end
    endtask

    initial begin
        lcg_state    = 32'd15;
        total_errs   = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        test_errs    = 0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        T            = 4'd0;
        in_data2     = 8'd0;
        w_Q          = 8'd0;
        w_K          = 8'd0;
        w_V          = 8'd0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // outputs stay quiet while idle after reset
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            #2;
            check_quiet();
        end
        total_errs += test_errs;
        for (int n = 0; n < num_tests; n++) begin
            run_test(n);
            if (timed_out) begin
                break;
            end
        end
        $display("%0d tests, %0d failed, %0d errors", num_tests, failed_tests, total_errs);
        if (total_errs == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: logic/attn_top.sv
module attn_top import attn_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  seq_len_t T,
    input  elem_t    in_data2,
    input  elem_t    w_Q,
    input  elem_t    w_K,
    input  elem_t    w_V,
    output logic     out_valid,
    output out_t     out_data
);

    step_t         step;
    seq_len_t      seq_len;
    in_mats_t      in_mats;
    proj_mats_t    proj_mats;
    score_t [63:0] scores;

    attn_sequencer i_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .seq_len  (seq_len),
        .step     (step)
    );

    input_buffer i_input_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .T        (T),
        .in_data2 (in_data2),
        .w_Q      (w_Q),
        .w_K      (w_K),
        .w_V      (w_V),
        .seq_len  (seq_len),
        .in_mats  (in_mats)
    );

    projection_unit i_projection (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .in_mats   (in_mats),
        .proj_mats (proj_mats)
    );

    score_unit i_score (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .proj_mats (proj_mats),
        .scores    (scores)
    );

    context_unit i_context (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .proj_mats (proj_mats),
        .scores    (scores),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: attention/context_unit.sv
`include "attn_consts.svh"

module context_unit import attn_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  step_t         step,
    input  proj_mats_t    proj_mats,
    input  score_t [63:0] scores,
    output logic          out_valid,
    output out_t          out_data
);

    logic               ctx_step;
    score_t             ops [`ATTN_DIM];
    proj_t              opv [`ATTN_DIM];
    logic               op_valid;
    logic signed [58:0] dot;

    assign ctx_step = step.active && (step.phase == ph_context);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= ctx_step;
        end
    end

    // score row i against v column j
    always_ff @(posedge clk) begin
        if (ctx_step) begin
            for (int k = 0; k < `ATTN_DIM; k++) begin
                ops[k] <= scores[{step.idx[5:3], 3'(k)}];
                opv[k] <= proj_mats.v[{3'(k), step.idx[2:0]}];
            end
        end
    end

    // scores past T are zero, so all eight lanes can run
    always_comb begin
        dot = '0;
        for (int k = 0; k < `ATTN_DIM; k++) begin
            dot = dot + 59'(ops[k] * opv[k]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= op_valid;
            out_data  <= op_valid ? dot[55:0] : '0;
        end
    end

endmodule

// File: attention/score_unit.sv
`include "attn_consts.svh"

module score_unit import attn_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  step_t         step,
    input  proj_mats_t    proj_mats,
    output score_t [63:0] scores
);

    logic               score_step;
    proj_t              opq [`ATTN_DIM];
    proj_t              opk [`ATTN_DIM];
    logic               st_valid;
    idx_t               st_idx;
    logic signed [39:0] dot;
    logic [38:0]        dot_pos;
    logic [38:0]        quot;

    assign score_step = step.active && (step.phase == ph_score);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
            st_idx   <= '0;
        end else begin
            st_valid <= score_step;
            st_idx   <= step.idx;
        end
    end

    // q row i and k row j, so no transpose is needed
    always_ff @(posedge clk) begin
        if (score_step) begin
            for (int k = 0; k < `ATTN_DIM; k++) begin
                opq[k] <= proj_mats.q[{step.idx[5:3], 3'(k)}];
                opk[k] <= proj_mats.k[{step.idx[2:0], 3'(k)}];
            end
        end
    end

    always_comb begin
        dot = '0;
        for (int k = 0; k < `ATTN_DIM; k++) begin
            dot = dot + 40'(opq[k] * opk[k]);
        end
    end

    // negative scores clip to zero before scaling
    assign dot_pos = dot[39] ? 39'd0 : dot[38:0];
    assign quot    = dot_pos / 39'(`ATTN_SCORE_DIV);

    // entries outside the T x T square stay zero
    always_ff @(posedge clk) begin
        if (step.phase == ph_load) begin
            scores <= '0;
        end else if (st_valid) begin
            scores[st_idx] <= score_t'(quot);
        end
    end

endmodule

// File: projection/projection_unit.sv
`include "attn_consts.svh"

module projection_unit import attn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  step_t      step,
    input  in_mats_t   in_mats,
    output proj_mats_t proj_mats
);

    logic         proj_step;
    elem_t [63:0] w_sel;
    elem_t        opx [`ATTN_DIM];
    elem_t        opw [`ATTN_DIM];
    logic         st_valid;
    idx_t         st_idx;
    phase_t       st_phase;
    proj_t        dot;

    assign proj_step = step.active && (step.phase inside {ph_proj_q, ph_proj_k, ph_proj_v});

    // weight matrix follows the phase
    always_comb begin
        case (step.phase)
            ph_proj_k: w_sel = in_mats.wk;
            ph_proj_v: w_sel = in_mats.wv;
            default:   w_sel = in_mats.wq;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
            st_idx   <= '0;
            st_phase <= ph_idle;
        end else begin
            st_valid <= proj_step;
            st_idx   <= step.idx;
            st_phase <= step.phase;
        end
    end

    // x row against weight column
    always_ff @(posedge clk) begin
        if (proj_step) begin
            for (int k = 0; k < `ATTN_DIM; k++) begin
                opx[k] <= in_mats.x[{step.idx[5:3], 3'(k)}];
                opw[k] <= w_sel[{3'(k), step.idx[2:0]}];
            end
        end
    end

    always_comb begin
        dot = '0;
        for (int k = 0; k < `ATTN_DIM; k++) begin
            dot = dot + proj_t'(opx[k] * opw[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (step.phase == ph_load) begin
            proj_mats <= '0;
        end else if (st_valid) begin
            case (st_phase)
                ph_proj_q: proj_mats.q[st_idx] <= dot;
                ph_proj_k: proj_mats.k[st_idx] <= dot;
                default:   proj_mats.v[st_idx] <= dot;
            endcase
        end
    end

endmodule

// File: logic/input_buffer.sv
`include "attn_consts.svh"

module input_buffer import attn_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  seq_len_t T,
    input  elem_t    in_data2,
    input  elem_t    w_Q,
    input  elem_t    w_K,
    input  elem_t    w_V,
    output seq_len_t seq_len,
    output in_mats_t in_mats
);

    logic [7:0] load_cnt;
    logic       first;
    seq_len_t   cur_len;
    logic       row_ok;
    logic       x_wr;
    idx_t       wr_idx;

    assign first  = in_valid && (load_cnt == 8'd0);
    assign wr_idx = load_cnt[5:0];

    // T is only on the bus in the first cycle
    assign cur_len = first ? T : seq_len;

    always_comb begin
        case (cur_len)
            4'd1:    row_ok = (load_cnt[5:3] == 3'd0);
            4'd4:    row_ok = (load_cnt[5:3] < 3'd4);
            default: row_ok = 1'b1;
        endcase
    end

    assign x_wr = in_valid && row_ok && (load_cnt < 8'(`ATTN_DIM * `ATTN_DIM));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_cnt <= '0;
            seq_len  <= '0;
        end else begin
            load_cnt <= in_valid ? load_cnt + 8'd1 : 8'd0;
            if (first) begin
                seq_len <= T;
            end
        end
    end

    // ##################################################################
    // matrix capture
    // ##################################################################
    always_ff @(posedge clk) begin
        // rows at or beyond T must read as zero for short jobs
        if (first) begin
            in_mats.x <= '0;
        end
        if (x_wr) begin
            in_mats.x[wr_idx] <= in_data2;
        end

        if (in_valid) begin
            if (load_cnt < 8'(`ATTN_WK_FIRST)) begin
                in_mats.wq[wr_idx] <= w_Q;
            end else if (load_cnt < 8'(`ATTN_WV_FIRST)) begin
                in_mats.wk[wr_idx] <= w_K;
            end else if (load_cnt < 8'(`ATTN_LOAD_CYCLES)) begin
                in_mats.wv[wr_idx] <= w_V;
            end
        end
    end

endmodule

// File: logic/attn_sequencer.sv
`include "attn_consts.svh"

module attn_sequencer import attn_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  seq_len_t seq_len,
    output step_t    step
);

    phase_t     phase;
    phase_t     next_phase;
    idx_t       idx;
    logic [7:0] load_cnt;
    logic [1:0] drain_cnt;
    logic       gap;
    logic [2:0] last_row;
    logic [2:0] last_col;
    logic       col_last;
    logic       phase_done;
    logic       compute;

    // T of 1 or 4 is kept, anything else runs the full matrix
    always_comb begin
        case (seq_len)
            4'd1:    last_row = 3'd0;
            4'd4:    last_row = 3'd3;
            default: last_row = 3'(`ATTN_DIM - 1);
        endcase
    end

    // score walks a T x T square, the other phases T rows of 8
    assign last_col   = (phase == ph_score) ? last_row : 3'(`ATTN_DIM - 1);
    assign col_last   = (idx[2:0] == last_col);
    assign phase_done = col_last && (idx[5:3] == last_row);
    assign compute    = phase inside {ph_proj_q, ph_proj_k, ph_proj_v, ph_score, ph_context};

    always_comb begin
        case (phase)
            ph_load:   next_phase = ph_proj_q;
            ph_proj_q: next_phase = ph_proj_k;
            ph_proj_k: next_phase = ph_proj_v;
            ph_proj_v: next_phase = ph_score;
            ph_score:  next_phase = ph_context;
            default:   next_phase = ph_drain;
        endcase
    end

    // ##################################################################
    // phase FSM
    // ##################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= ph_idle;
            idx       <= '0;
            load_cnt  <= '0;
            drain_cnt <= '0;
            gap       <= 1'b0;
        end else begin
            case (phase)
                ph_idle: begin
                    load_cnt <= '0;
                    if (in_valid) begin
                        phase <= ph_load;
                    end
                end
                ph_load: begin
                    load_cnt <= load_cnt + 8'd1;
                    if (load_cnt == 8'(`ATTN_LOAD_CYCLES - 1)) begin
                        phase <= next_phase;
                        idx   <= '0;
                        gap   <= 1'b1;
                    end
                end
                ph_drain: begin
                    drain_cnt <= drain_cnt + 2'd1;
                    if (drain_cnt == 2'(`ATTN_PIPE_DEPTH - 1)) begin
                        phase <= ph_idle;
                    end
                end
                default: begin
                    // one bubble lets the last result of the previous phase land
                    if (gap) begin
                        gap <= 1'b0;
                    end else if (phase_done) begin
                        phase     <= next_phase;
                        idx       <= '0;
                        drain_cnt <= '0;
                        gap       <= 1'b1;
                    end else if (col_last) begin
                        idx <= {idx[5:3] + 3'd1, 3'd0};
                    end else begin
                        idx <= idx + 6'd1;
                    end
                end
            endcase
        end
    end

    always_comb begin
        step.phase  = phase;
        step.idx    = idx;
        step.active = compute && !gap;
    end

endmodule

// File: common/attn_pkg.sv
package attn_pkg;

    // element widths
    typedef logic signed [7:0]  elem_t;
    typedef logic signed [18:0] proj_t;
    typedef logic signed [36:0] score_t;
    typedef logic signed [55:0] out_t;

    // row in [5:3], column in [2:0]
    typedef logic [5:0] idx_t;
    typedef logic [3:0] seq_len_t;

    typedef enum logic [2:0] {
        ph_idle,
        ph_load,
        ph_proj_q,
        ph_proj_k,
        ph_proj_v,
        ph_score,
        ph_context,
        ph_drain
    } phase_t;

    // per-cycle command from the sequencer
    typedef struct packed {
        phase_t phase;
        idx_t   idx;
        logic   active;
    } step_t;

    typedef struct packed {
        elem_t [63:0] x;
        elem_t [63:0] wq;
        elem_t [63:0] wk;
        elem_t [63:0] wv;
    } in_mats_t;

    typedef struct packed {
        proj_t [63:0] q;
        proj_t [63:0] k;
        proj_t [63:0] v;
    } proj_mats_t;

endpackage

// File: common/attn_consts.svh
`ifndef ATTN_CONSTS_SVH
`define ATTN_CONSTS_SVH

// matrix side, also the number of multiplier lanes per unit
`define ATTN_DIM 8

// in_valid stays high this many cycles per job
`define ATTN_LOAD_CYCLES 192

// weight stream windows inside the load phase
// wq arrives in the cycles before ATTN_WK_FIRST
`define ATTN_WK_FIRST 64
`define ATTN_WV_FIRST 128

// scaling of the clipped q.k dot product
`define ATTN_SCORE_DIV 3

// operand register plus result register
`define ATTN_PIPE_DEPTH 2

`endif
